//--- Bender.yml
package:
  name: pocket_core

export_include_dirs:
  - include

sources:
  - files:
      - source/core_pkg.sv
      - source/video_timing.sv
      - source/square_painter.sv
      - source/i2s_framer.sv
      - source/pocket_core.sv
  - target: simulation
    files:
      - tb/pocket_core_asserts.sv
      - tb/pocket_core_tb.sv

//--- include/core_defs.svh
/*
 * raster geometry for the 320x240 picture
 * bouncing square size and background level
 * i2s bit clock and word clock dividers
 */

`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// horizontal raster, in mclk cycles
`define VID_H_BPORCH    (10'd10)
`define VID_H_ACTIVE    (10'd320)
`define VID_H_TOTAL     (10'd400)

// vertical raster, in lines
`define VID_V_BPORCH    (10'd10)
`define VID_V_ACTIVE    (10'd240)
`define VID_V_TOTAL     (10'd512)

// hs sits a few clocks after vs
`define VID_HS_COLUMN   (10'd3)

`define SQUARE_SIZE     (10'd15)
`define BG_LEVEL        (8'd60)

// sclk = mclk / 4, lrck half = 32 sclk
`define SCLK_DIV_BITS   2
`define LRCK_HALF_BITS  32

`endif

//--- sim.f
+incdir+include
source/core_pkg.sv
source/video_timing.sv
source/square_painter.sv
source/i2s_framer.sv
source/pocket_core.sv
tb/pocket_core_asserts.sv
tb/pocket_core_tb.sv

//--- source/core_pkg.sv
/*
 * shared types for the video and audio generators
 * coordinates, colour, raster strobes, square position
 * video and i2s output bundles
 */

package core_pkg;

    // raster or screen coordinate
    typedef logic [9:0] coord_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // counters plus decoded strobes
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   frame_start;
        logic   line_sync;
        logic   active;
    } raster_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } square_pos_t;

    // to the scaler
    typedef struct packed {
        rgb_t rgb;
        logic de;
        logic skip;
        logic vs;
        logic hs;
    } video_out_t;

    typedef struct packed {
        logic sclk;
        logic lrck;
        logic dac;
    } i2s_out_t;

endpackage

//--- source/i2s_framer.sv
/*
 * i2s frame generator for silence
 * bit clock divider, word clock counter, zero data line
 */

`timescale 1ns/1ps

`include "core_defs.svh"

module i2s_framer import core_pkg::*; (
    input  logic     audgen_mclk,
    input  logic     reset_n,
    output i2s_out_t audio
);

    localparam int unsigned CNT_W = $clog2(`LRCK_HALF_BITS);
    localparam logic [CNT_W-1:0] LRCK_LAST = CNT_W'(`LRCK_HALF_BITS - 1);

    logic [`SCLK_DIV_BITS-1:0] mclk_div;
    logic [CNT_W-1:0]          bit_cnt;
    logic                      lrck;
    logic                      sclk_fall;

    // divider about to wrap, so sclk drops on this edge
    assign sclk_fall = &mclk_div;

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            mclk_div <= '0;
            bit_cnt  <= '0;
            lrck     <= 1'b0;
        end else begin
            mclk_div <= mclk_div + 1'b1;
            if (sclk_fall) begin
                bit_cnt <= bit_cnt + 1'b1;
                // switch channel after 32 bits
                if (bit_cnt == LRCK_LAST) begin
                    lrck <= ~lrck;
                end
            end
        end
    end

    // msb of the divider is the bit clock
    assign audio.sclk = mclk_div[`SCLK_DIV_BITS-1];
    assign audio.lrck = lrck;
    // silent data line
    assign audio.dac  = 1'b0;

endmodule

//--- source/pocket_core.sv
/*
 * core top level
 * raster timing, square painter and i2s framer on one clock
 */

`timescale 1ns/1ps

module pocket_core import core_pkg::*; #(
    parameter coord_t square_x_init = 10'd135,
    parameter coord_t square_y_init = 10'd95
) (
    input  logic       audgen_mclk,
    input  logic       reset_n,
    output video_out_t video,
    output i2s_out_t   audio
);

    // counters and strobes to the painter
    raster_t raster;

    //////////////////////////////////////////////////
    // video
    //////////////////////////////////////////////////

    video_timing i_video_timing (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .raster      (raster)
    );

    square_painter #(
        .square_x_init (square_x_init),
        .square_y_init (square_y_init)
    ) i_square_painter (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .raster      (raster),
        .video       (video)
    );

    //////////////////////////////////////////////////
    // audio
    //////////////////////////////////////////////////

    i2s_framer i_i2s_framer (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .audio       (audio)
    );

endmodule

//--- source/square_painter.sv
/*
 * bouncing square position and direction state
 * pixel colouring and registered video outputs
 */

`timescale 1ns/1ps

`include "core_defs.svh"

module square_painter import core_pkg::*; #(
    parameter coord_t square_x_init = 10'd135,
    parameter coord_t square_y_init = 10'd95
) (
    input  logic       audgen_mclk,
    input  logic       reset_n,
    input  raster_t    raster,
    output video_out_t video
);

    // upper limits of the square's top left corner
    localparam coord_t X_MAX = `VID_H_ACTIVE - `SQUARE_SIZE;
    localparam coord_t Y_MAX = `VID_V_ACTIVE - `SQUARE_SIZE;

    localparam rgb_t GREY = '{r: `BG_LEVEL, g: `BG_LEVEL, b: `BG_LEVEL};

    square_pos_t pos;
    square_pos_t pos_nxt;
    // 1 = coordinate increasing (right or down on screen)
    logic        x_inc;
    logic        y_inc;
    logic        x_inc_nxt;
    logic        y_inc_nxt;

    coord_t      vis_x;
    coord_t      vis_y;
    logic        in_square;
    video_out_t  video_nxt;

    // direction after this frame's step
    // reverses when already at the limit it is heading for
    function automatic logic turn_dir(coord_t p, logic inc, coord_t lim_hi);
        if (inc) begin
            return (p != lim_hi);
        end
        return (p == '0);
    endfunction

    //////////////////////////////////////////////////
    // motion
    //////////////////////////////////////////////////

    always_comb begin
        x_inc_nxt = turn_dir(pos.x, x_inc, X_MAX);
        y_inc_nxt = turn_dir(pos.y, y_inc, Y_MAX);
        pos_nxt.x = x_inc_nxt ? pos.x + 10'd1 : pos.x - 10'd1;
        pos_nxt.y = y_inc_nxt ? pos.y + 10'd1 : pos.y - 10'd1;
    end

    // one step per frame, new frame drawn at new spot
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            pos   <= '{x: square_x_init, y: square_y_init};
            // left and down
            x_inc <= 1'b0;
            y_inc <= 1'b1;
        end else if (raster.frame_start) begin
            pos   <= pos_nxt;
            x_inc <= x_inc_nxt;
            y_inc <= y_inc_nxt;
        end
    end

    //////////////////////////////////////////////////
    // pixel colour
    //////////////////////////////////////////////////

    // only meaningful inside the active area
    assign vis_x = raster.x - `VID_H_BPORCH;
    assign vis_y = raster.y - `VID_V_BPORCH;

    assign in_square = (vis_x >= pos.x) && (vis_x < pos.x + `SQUARE_SIZE) &&
                       (vis_y >= pos.y) && (vis_y < pos.y + `SQUARE_SIZE);

    always_comb begin
        video_nxt      = '0;
        video_nxt.hs   = raster.line_sync;
        video_nxt.vs   = raster.frame_start;
        video_nxt.de   = raster.active;
        video_nxt.skip = 1'b0;
        // black border, grey field, black square
        if (raster.active && !in_square) begin
            video_nxt.rgb = GREY;
        end
    end

    // output register, one clock behind the counters
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video <= '0;
        end else begin
            video <= video_nxt;
        end
    end

endmodule

//--- source/video_timing.sv
/*
 * column and line counters for the 400x512 raster
 * frame start, line sync and active area decode
 */

`timescale 1ns/1ps

`include "core_defs.svh"

module video_timing import core_pkg::*; (
    input  logic    audgen_mclk,
    input  logic    reset_n,
    output raster_t raster
);

    coord_t h_count;
    coord_t v_count;

    logic h_last;
    logic v_last;
    logic h_in_active;
    logic v_in_active;

    //////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////

    assign h_last = (h_count == `VID_H_TOTAL - 10'd1);
    assign v_last = (v_count == `VID_V_TOTAL - 10'd1);

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            if (h_last) begin
                h_count <= '0;
                // next line, wrap at end of frame
                if (v_last) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 10'd1;
                end
            end else begin
                h_count <= h_count + 10'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // strobe decode
    //////////////////////////////////////////////////

    // back porch up to end of visible area
    assign h_in_active = (h_count >= `VID_H_BPORCH) &&
                         (h_count < `VID_H_BPORCH + `VID_H_ACTIVE);
    assign v_in_active = (v_count >= `VID_V_BPORCH) &&
                         (v_count < `VID_V_BPORCH + `VID_V_ACTIVE);

    assign raster.x           = h_count;
    assign raster.y           = v_count;
    // first clock of the frame
    assign raster.frame_start = (h_count == '0) && (v_count == '0);
    assign raster.line_sync   = (h_count == `VID_HS_COLUMN);
    assign raster.active      = h_in_active && v_in_active;

endmodule

//--- tb/pocket_core_asserts.sv
/*
 * concurrent assertions on the core outputs
 * bound into the core top level
 */

`timescale 1ns/1ps

module pocket_core_asserts import core_pkg::*; (
    input logic       audgen_mclk,
    input logic       reset_n,
    input video_out_t video,
    input i2s_out_t   audio
);

    int unsigned error_count = 0;

    // vs is a single-cycle pulse
    vs_single: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        video.vs |=> !video.vs)
        else begin
            error_count = error_count + 1;
            $error("vs high on two consecutive cycles");
        end

    // silence
    dac_zero: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        !audio.dac)
        else begin
            error_count = error_count + 1;
            $error("dac not zero");
        end

    skip_zero: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        !video.skip)
        else begin
            error_count = error_count + 1;
            $error("skip not zero");
        end

    // black outside the data enable window
    rgb_blank: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        !video.de |-> (video.rgb == '0))
        else begin
            error_count = error_count + 1;
            $error("rgb not zero while de is low");
        end

endmodule

bind pocket_core pocket_core_asserts i_pocket_core_asserts (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .video       (video),
    .audio       (audio)
);

//--- tb/pocket_core_tb.sv
/*
 * directed testbench for the core top level
 * reset, i2s framing, raster timing, colours, square bounce
 * compare tasks per output type, square position model
 */

`timescale 1ns/1ps

module pocket_core_tb import core_pkg::*; ();

    // raster numbers in mclk cycles and lines
    localparam int     LINE_CLKS   = 400;
    localparam int     FRAME_LINES = 512;
    localparam int     HS_COL      = 3;
    // de starts 7 after hs
    localparam int     DE_COL      = 10;
    localparam int     DE_LINE     = 10;
    localparam int     VIS_W       = 320;
    localparam int     VIS_H       = 240;
    localparam int     SQ          = 15;
    localparam rgb_t   GREY        = 24'h3c3c3c;
    localparam int     VS_TIMEOUT  = LINE_CLKS * FRAME_LINES + 16;
    localparam coord_t SQ_X_INIT   = 10'd2;
    localparam coord_t SQ_Y_INIT   = 10'd222;

    logic       audgen_mclk;
    logic       reset_n;
    video_out_t video;
    i2s_out_t   audio;

    // expected square state
    square_pos_t model_pos;
    logic        model_right;
    logic        model_down;

    pocket_core #(
        .square_x_init (SQ_X_INIT),
        .square_y_init (SQ_Y_INIT)
    ) i_pocket_core (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .video       (video),
        .audio       (audio)
    );

    initial begin
        audgen_mclk = 1'b0;
        forever #10 audgen_mclk = ~audgen_mclk;
    end

    //////////////////////////////////////////////////
    // reporting and compare
    //////////////////////////////////////////////////

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_video(video_out_t got, video_out_t exp, string name);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_square(square_pos_t got, square_pos_t exp, string name);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_audio(i2s_out_t got, i2s_out_t exp, string name);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // bound assertions count their failures
    always @(negedge audgen_mclk) begin
        if (i_pocket_core.i_pocket_core_asserts.error_count != 0) begin
            report_failure("an assertion on the core outputs failed");
        end
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic apply_reset();
        @(posedge audgen_mclk);
        reset_n <= 1'b0;
        repeat (3) begin
            @(negedge audgen_mclk);
            check_video(video, '0, "video in reset");
            check_audio(audio, '0, "audio in reset");
        end
        @(posedge audgen_mclk);
        reset_n <= 1'b1;
        // first cycle after release
        @(negedge audgen_mclk);
        check_video(video, '0, "video after reset");
        check_audio(audio, '0, "audio after reset");
    endtask

    // turn at the edge it heads for, then one step
    task automatic step_model();
        if (model_right && model_pos.x == VIS_W - SQ) begin
            model_right = 1'b0;
        end else if (!model_right && model_pos.x == 0) begin
            model_right = 1'b1;
        end
        if (model_down && model_pos.y == VIS_H - SQ) begin
            model_down = 1'b0;
        end else if (!model_down && model_pos.y == 0) begin
            model_down = 1'b1;
        end
        model_pos.x = model_right ? model_pos.x + 10'd1 : model_pos.x - 10'd1;
        model_pos.y = model_down ? model_pos.y + 10'd1 : model_pos.y - 10'd1;
    endtask

    // sync and de timing, grey field, black outside de
    function automatic video_out_t expected_video(int line, int col);
        video_out_t v;
        int         vx;
        int         vy;
        v    = '0;
        vx   = col - DE_COL;
        vy   = line - DE_LINE;
        v.vs = (line == 0) && (col == 0);
        v.hs = (col == HS_COL);
        v.de = (vx >= 0) && (vx < VIS_W) && (vy >= 0) && (vy < VIS_H);
        if (v.de) begin
            v.rgb = GREY;
        end
        return v;
    endfunction

    task automatic wait_vs(output int waited);
        waited = 0;
        do begin
            @(negedge audgen_mclk);
            waited++;
        end while (!video.vs && waited < VS_TIMEOUT);
        if (!video.vs) begin
            report_failure("timed out waiting for vs");
        end
    endtask

    // entered on the vs cycle, leaves on the next vs cycle
    task automatic scan_frame();
        int          c;
        int          line;
        int          col;
        int          cnt;
        int          min_x;
        int          max_x;
        int          min_y;
        int          max_y;
        video_out_t  exp_v;
        square_pos_t seen;
        cnt   = 0;
        min_x = VIS_W;
        max_x = -1;
        min_y = VIS_H;
        max_y = -1;
        for (c = 0; c < LINE_CLKS * FRAME_LINES; c++) begin
            if (c != 0) begin
                @(negedge audgen_mclk);
            end
            line  = c / LINE_CLKS;
            col   = c % LINE_CLKS;
            exp_v = expected_video(line, col);
            // black inside de belongs to the square, measured below
            if (exp_v.de && video.rgb == '0) begin
                exp_v.rgb = '0;
                cnt++;
                min_x = (col - DE_COL < min_x) ? col - DE_COL : min_x;
                max_x = (col - DE_COL > max_x) ? col - DE_COL : max_x;
                min_y = (line - DE_LINE < min_y) ? line - DE_LINE : min_y;
                max_y = (line - DE_LINE > max_y) ? line - DE_LINE : max_y;
            end
            check_video(video, exp_v, "video");
        end
        // next vs exactly one frame later
        @(negedge audgen_mclk);
        check_video(video, expected_video(0, 0), "video at next vs");
        if (cnt != SQ * SQ || max_x - min_x != SQ - 1 || max_y - min_y != SQ - 1) begin
            report_failure("black pixels do not form one 15x15 square");
        end
        seen.x = coord_t'(min_x);
        seen.y = coord_t'(min_y);
        check_square(seen, model_pos, "square position");
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_state();
        apply_reset();
    endtask

    // sample k counts mclk from the first cycle after reset
    task automatic test_i2s_framing();
        i2s_out_t exp;
        int       k;
        for (k = 0; k < 1024; k++) begin
            if (k != 0) begin
                @(negedge audgen_mclk);
            end
            exp.sclk = (k % 4) >= 2;
            // flips on a falling sclk every 128 mclk
            exp.lrck = ((k / 128) % 2) == 1;
            exp.dac  = 1'b0;
            check_audio(audio, exp, "audio");
        end
    endtask

    task automatic test_raster_timing();
        int waited;
        apply_reset();
        model_pos   = '{x: SQ_X_INIT, y: SQ_Y_INIT};
        model_right = 1'b0;
        model_down  = 1'b1;
        wait_vs(waited);
        if (waited != 1) begin
            report_failure("vs did not come in the second cycle after reset");
        end
        // frame 1
        step_model();
        scan_frame();
    endtask

    task automatic test_colours();
        step_model();
        scan_frame();
    endtask

    // frames 3 to 6, both bounces
    task automatic test_square_motion();
        repeat (4) begin
            step_model();
            scan_frame();
        end
    endtask

    initial begin
        reset_n = 1'b0;
        test_reset_state();
        test_i2s_framing();
        test_raster_timing();
        test_colours();
        test_square_motion();
        if (i_pocket_core.i_pocket_core_asserts.error_count != 0) begin
            report_failure("an assertion on the core outputs failed");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule
